// ==== include/fetch_cfg.svh ====
// --------------------
// Build-time sizing of the fetch front end
// IMEM_AW must equal log2(IMEM_WORDS)
// FETCH_START_ADDR must be word aligned and inside the memory
// --------------------
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define FETCH_START_ADDR 32'h0000_0000 // Pc value out of reset
`define IMEM_WORDS       256           // Instruction memory depth in words
`define IMEM_AW          8             // Word index width
`define FETCH_TAG_W      3             // Flush tag width, wraps silently

`endif

// ==== logic/instr_pkg.sv ====
// --------------------
// RV32I instruction formats seen by the predecoder
// Compressed encodings are not covered
// --------------------
package instr_pkg;

    localparam logic [6:0] OPC_BRANCH = 7'b110_0011; // BEQ, BNE, BLT, BGE, BLTU, BGEU
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;   // Same bit position as in b_type_t
    } j_type_t;

    typedef union packed {
        logic [31:0] raw;
        b_type_t     b;
        j_type_t     j;
    } instr_u;

endpackage

// ==== logic/mem_pkg.sv ====
// --------------------
// Shared instruction memory port
// Only two owners exist, fetch and the APB loader
// --------------------
`include "fetch_cfg.svh"

package mem_pkg;

    typedef logic [`IMEM_AW-1:0] word_idx_t; // Byte address bits IMEM_AW+1:2

    // Who drives the memory port in the current cycle
    typedef enum logic {
        OWNER_FETCH  = 1'b0,
        OWNER_LOADER = 1'b1
    } owner_e;

endpackage

// ==== logic/fetch_unit.sv ====
// --------------------
// Pc, redirect priority and flush tag
// Targets are assumed word aligned, no misalign trap
// Prediction is dropped while a redirect is pending
// --------------------
`include "fetch_cfg.svh"

module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,          // Memory port owned by the loader
    input  logic                    hazard_i,
    input  logic                    jump_i,
    input  logic [31:0]             jump_target_i,
    input  logic                    predict_taken_i,
    input  logic [31:0]             predict_target_i,
    input  logic [31:0]             mtvec_i,
    input  logic [31:0]             mepc_i,
    input  logic                    exception_i,
    input  logic                    mret_i,
    input  logic                    irq_ack_i,
    output logic [31:0]             instruction_address_o,
    output logic [31:0]             pc_o,
    output logic [`FETCH_TAG_W-1:0] tag_o
);

    logic [31:0]             pc;
    logic [31:0]             pc_plus4;
    logic [`FETCH_TAG_W-1:0] current_tag;
    logic [`FETCH_TAG_W-1:0] next_tag;
    logic                    advance;
    logic                    redirect;
    logic                    take_pred;

    assign advance  = !hazard_i && !stall_i;                   // Fetch may move on
    assign redirect = mret_i || exception_i || irq_ack_i || jump_i;

    // A differing tag pair means pc_o is a stale fetch from before a redirect,
    // so its prediction must not steer the new stream
    assign take_pred = predict_taken_i && advance && !redirect
                       && (current_tag == next_tag);

    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FETCH_START_ADDR;
        end else if (mret_i) begin
            pc <= mepc_i;                                      // Return wins over all
        end else if (exception_i || irq_ack_i) begin
            pc <= mtvec_i;
        end else if (jump_i) begin
            pc <= jump_target_i;
        end else if (take_pred) begin
            pc <= predict_target_i + 32'd4;                    // Target itself is issued now
        end else if (advance) begin
            pc <= pc_plus4;
        end
    end

    // Address goes out this cycle, the word returns next cycle
    assign instruction_address_o = take_pred ? predict_target_i : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= `FETCH_START_ADDR;
        end else if (advance) begin
            pc_o <= instruction_address_o;                     // Lines up with imem rdata
        end
    end

    // Two-register tag calculator
    always_ff @(posedge clk) begin
        if (reset) begin
            next_tag    <= '0;
            current_tag <= '0;
        end else begin
            if (redirect) begin
                next_tag <= current_tag + 1'b1;                // New stream id
            end
            if (advance) begin
                current_tag <= next_tag;                       // First word of new stream
            end
        end
    end

    assign tag_o = current_tag;

endmodule

// ==== logic/branch_predecoder.sv ====
// --------------------
// Static predictor, no history
// JAL always taken, conditional branch taken only when backward
// JALR is not predicted
// --------------------
module branch_predecoder (
    input  instr_pkg::instr_u instr_i,
    input  logic [31:0]       pc_i,             // Address of instr_i
    input  logic              valid_i,
    output logic              predict_taken_o,
    output logic [31:0]       predict_target_o
);

    logic        is_jal;
    logic        is_branch;
    logic [31:0] imm_j;
    logic [31:0] imm_b;

    // Opcode field sits in the same bits for both views
    assign is_jal    = (instr_i.j.opcode == instr_pkg::OPC_JAL);
    assign is_branch = (instr_i.b.opcode == instr_pkg::OPC_BRANCH);

    // J-type immediate, 21 bits sign extended
    assign imm_j = {{11{instr_i.j.imm20}},
                    instr_i.j.imm20,
                    instr_i.j.imm19_12,
                    instr_i.j.imm11,
                    instr_i.j.imm10_1,
                    1'b0};

    // B-type immediate, 13 bits sign extended
    assign imm_b = {{19{instr_i.b.imm12}},
                    instr_i.b.imm12,
                    instr_i.b.imm11,
                    instr_i.b.imm10_5,
                    instr_i.b.imm4_1,
                    1'b0};

    // Backward branch means negative offset, imm12 is the sign bit
    assign predict_taken_o = valid_i && (is_jal || (is_branch && instr_i.b.imm12));

    assign predict_target_o = pc_i + (is_jal ? imm_j : imm_b);

endmodule

// ==== logic/imem_arbiter.sv ====
// --------------------
// One memory port, two masters
// Loader gets the port one cycle after it asks and keeps it for one cycle
// Fetch stall is registered, no path from loader request to fetch address
// --------------------
module imem_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::word_idx_t f_idx_i,
    input  logic               ld_req_i,
    input  logic               ld_we_i,
    input  mem_pkg::word_idx_t ld_idx_i,
    input  logic [31:0]        ld_wdata_i,
    output logic               ld_gnt_o,
    output logic               fetch_stall_o,
    output logic               mem_en_o,
    output logic               mem_we_o,
    output mem_pkg::word_idx_t mem_idx_o,
    output logic [31:0]        mem_wdata_o
);

    mem_pkg::owner_e owner_q;

    assign ld_gnt_o = ld_req_i && (owner_q == mem_pkg::OWNER_LOADER);

    // Loader wins on any pending request, port goes back to fetch after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            owner_q <= mem_pkg::OWNER_FETCH;
        end else if (ld_req_i && !ld_gnt_o) begin
            owner_q <= mem_pkg::OWNER_LOADER;
        end else begin
            owner_q <= mem_pkg::OWNER_FETCH;
        end
    end

    assign fetch_stall_o = (owner_q == mem_pkg::OWNER_LOADER);

    // Fetch reads every cycle it owns the port
    assign mem_en_o    = fetch_stall_o ? ld_gnt_o : 1'b1;
    assign mem_we_o    = ld_gnt_o && ld_we_i;               // Fetch never writes
    assign mem_idx_o   = fetch_stall_o ? ld_idx_i : f_idx_i;
    assign mem_wdata_o = ld_wdata_i;                        // Only sampled on a loader write

endmodule

// ==== logic/imem.sv ====
// --------------------
// Single-port word memory
// Read data registered, old data on a write cycle
// Contents undefined until loaded over APB
// --------------------
`include "fetch_cfg.svh"

module imem (
    input  logic               clk,
    input  logic               en_i,
    input  logic               we_i,
    input  mem_pkg::word_idx_t idx_i,
    input  logic [31:0]        wdata_i,
    output logic [31:0]        rdata_o
);

    logic [31:0] mem [`IMEM_WORDS];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[idx_i] <= wdata_i;
            end else begin
                rdata_o <= mem[idx_i];      // Valid on the next cycle
            end
        end
    end

endmodule

// ==== logic/apb_loader.sv ====
// --------------------
// APB slave into instruction memory
// No pslverr, upper address bits are ignored
// Master must hold psel and the address until pready
// --------------------
`include "fetch_cfg.svh"

module apb_loader (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  logic [31:0]        paddr_i,      // Byte address
    input  logic [31:0]        pwdata_i,
    input  logic               ld_gnt_i,
    input  logic [31:0]        mem_rdata_i,
    output logic [31:0]        prdata_o,
    output logic               pready_o,
    output logic               ld_req_o,
    output logic               ld_we_o,
    output mem_pkg::word_idx_t ld_idx_o,
    output logic [31:0]        ld_wdata_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,        // Waiting for the port
        ST_RESP        // Memory done, finish the APB access
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   setup;

    assign setup = psel_i && !penable_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (setup) state_d = ld_gnt_i ? ST_RESP : ST_REQ;
            ST_REQ:  if (ld_gnt_i) state_d = ST_RESP;
            ST_RESP: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request starts in the setup cycle and is held until granted
    assign ld_req_o   = (state_q == ST_IDLE && setup) || (state_q == ST_REQ);
    assign ld_we_o    = pwrite_i;
    assign ld_idx_o   = paddr_i[`IMEM_AW+1:2];
    assign ld_wdata_o = pwdata_i;

    // Read word lands one cycle after the grant, same cycle as pready
    assign pready_o = (state_q == ST_RESP);
    assign prdata_o = (pready_o && !pwrite_i) ? mem_rdata_i : '0;

endmodule

// ==== logic/fetch_top.sv ====
// --------------------
// Fetch front end, memory and APB loader
// Trap and jump targets come from outside
// instr_o, pc_o and tag_o belong together, qualified by instr_valid_o
// --------------------
`include "fetch_cfg.svh"

module fetch_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hazard_i,
    input  logic                    jump_i,
    input  logic [31:0]             jump_target_i,
    input  logic [31:0]             mtvec_i,
    input  logic [31:0]             mepc_i,
    input  logic                    exception_i,
    input  logic                    mret_i,
    input  logic                    irq_ack_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [31:0]             paddr_i,
    input  logic [31:0]             pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic [31:0]             pc_o,
    output logic [31:0]             instr_o,
    output logic [`FETCH_TAG_W-1:0] tag_o,
    output logic                    instr_valid_o
);

    logic [31:0]        fetch_addr;
    mem_pkg::word_idx_t f_idx;
    logic               predict_taken;
    logic [31:0]        predict_target;
    logic               fetch_stall;
    logic               ld_req;
    logic               ld_we;
    mem_pkg::word_idx_t ld_idx;
    logic [31:0]        ld_wdata;
    logic               ld_gnt;
    logic               mem_en;
    logic               mem_we;
    mem_pkg::word_idx_t mem_idx;
    logic [31:0]        mem_wdata;
    logic [31:0]        mem_rdata;
    instr_pkg::instr_u  instr_w;
    logic               valid_q;

    fetch_unit u_fetch (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (fetch_stall),
        .hazard_i              (hazard_i),
        .jump_i                (jump_i),
        .jump_target_i         (jump_target_i),
        .predict_taken_i       (predict_taken),
        .predict_target_i      (predict_target),
        .mtvec_i               (mtvec_i),
        .mepc_i                (mepc_i),
        .exception_i           (exception_i),
        .mret_i                (mret_i),
        .irq_ack_i             (irq_ack_i),
        .instruction_address_o (fetch_addr),
        .pc_o                  (pc_o),
        .tag_o                 (tag_o)
    );

    assign f_idx = fetch_addr[`IMEM_AW+1:2];     // Word index, low bits always zero
    assign instr_w.raw = mem_rdata;

    branch_predecoder u_predec (
        .instr_i          (instr_w),
        .pc_i             (pc_o),
        .valid_i          (valid_q),
        .predict_taken_o  (predict_taken),
        .predict_target_o (predict_target)
    );

    imem_arbiter u_arb (
        .clk           (clk),
        .reset         (reset),
        .f_idx_i       (f_idx),
        .ld_req_i      (ld_req),
        .ld_we_i       (ld_we),
        .ld_idx_i      (ld_idx),
        .ld_wdata_i    (ld_wdata),
        .ld_gnt_o      (ld_gnt),
        .fetch_stall_o (fetch_stall),
        .mem_en_o      (mem_en),
        .mem_we_o      (mem_we),
        .mem_idx_o     (mem_idx),
        .mem_wdata_o   (mem_wdata)
    );

    imem u_imem (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .idx_i   (mem_idx),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    apb_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .ld_gnt_i    (ld_gnt),
        .mem_rdata_i (mem_rdata),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .ld_req_o    (ld_req),
        .ld_we_o     (ld_we),
        .ld_idx_o    (ld_idx),
        .ld_wdata_o  (ld_wdata)
    );

    // Word on rdata is good only if last cycle's fetch owned the port and moved
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= !fetch_stall && !hazard_i;
        end
    end

    assign instr_o       = instr_w.raw;
    assign instr_valid_o = valid_q;

endmodule

// ==== test/fetch_checker.sv ====
// --------------------
// Assertions bound into the arbiter and the fetch unit
// ROLE 0 checks the arbiter, ROLE 1 the fetch unit
// Unused ports of a role are tied off in the bind
// --------------------
`include "fetch_cfg.svh"

module fetch_checker #(
    parameter int ROLE = 0
) (
    input logic            clk,
    input logic            reset,
    input logic            fetch_stall,
    input mem_pkg::owner_e owner,
    input logic            ld_req,
    input logic            ld_gnt,
    input logic [31:0]     pc
);

    // Stall covers exactly the cycle the loader is granted
    assert property (@(posedge clk) disable iff (reset || ROLE != 0)
        fetch_stall == ld_gnt)
        else $error("fetch stall does not match the loader grant");

    // A grant answers a request that waited one cycle behind fetch
    assert property (@(posedge clk) disable iff (reset || ROLE != 0)
        ld_gnt |-> $past(ld_req && owner == mem_pkg::OWNER_FETCH))
        else $error("loader granted without a pending request");

    // First cycle out of reset starts at the boot address
    assert property (@(posedge clk)
        (ROLE == 1) && $fell(reset) |-> pc == `FETCH_START_ADDR)
        else $error("pc is not the start address after reset");

endmodule

bind imem_arbiter fetch_checker #(.ROLE(0)) u_arb_chk (
    .clk         (clk),
    .reset       (reset),
    .fetch_stall (fetch_stall_o),
    .owner       (owner_q),
    .ld_req      (ld_req_i),
    .ld_gnt      (ld_gnt_o),
    .pc          (32'h0)
);

bind fetch_unit fetch_checker #(.ROLE(1)) u_fu_chk (
    .clk         (clk),
    .reset       (reset),
    .fetch_stall (stall_i),
    .owner       (mem_pkg::OWNER_FETCH),
    .ld_req      (1'b0),
    .ld_gnt      (1'b0),
    .pc          (pc)
);

// ==== test/fetch_tb.sv ====
// --------------------
// Testbench for fetch_top
// Program is loaded over APB with fetch held by hazard_i
// Expected pc, tag and word come from a cycle model of the fetch rules
// Table rows are {hazard, jump, exception, irq_ack, mret, apb phase}
// --------------------
`include "fetch_cfg.svh"

module fetch_tb;

    localparam int          PERIOD      = 20;
    localparam int          LOAD_WORDS  = 80;
    localparam int          N_ROWS      = 48;
    localparam int          TIMEOUT_CYC = N_ROWS + (LOAD_WORDS + 16) * 6 + 100;
    localparam logic [31:0] JUMP_TGT    = 32'h0000_0080;
    localparam logic [31:0] MTVEC       = 32'h0000_0100;
    localparam logic [31:0] MEPC        = 32'h0000_0040;
    localparam logic [31:0] RD_ADDR     = 32'h0000_0020; // Loader read target mid-run

    // Apb phase 1 is setup, 2 is access
    localparam logic [6:0] ROWS [N_ROWS] = '{
        7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, // Sequential, JAL at 0x18
        7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, // Fwd and back branch
        7'h20, 7'h00, 7'h00, 7'h00, 7'h10, 7'h00, 7'h00, 7'h00, // Jump, exception
        7'h08, 7'h00, 7'h00, 7'h00, 7'h34, 7'h00, 7'h00, 7'h00, // Irq, mret beats all
        7'h00, 7'h40, 7'h40, 7'h00, 7'h00, 7'h00, 7'h01, 7'h02, // Hazard, APB read
        7'h02, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00
    };

    logic                    clk;
    logic                    reset;
    logic                    hazard_i;
    logic                    jump_i;
    logic [31:0]             jump_target_i;
    logic [31:0]             mtvec_i;
    logic [31:0]             mepc_i;
    logic                    exception_i;
    logic                    mret_i;
    logic                    irq_ack_i;
    logic                    psel_i;
    logic                    penable_i;
    logic                    pwrite_i;
    logic [31:0]             paddr_i;
    logic [31:0]             pwdata_i;
    logic [31:0]             prdata_o;
    logic                    pready_o;
    logic [31:0]             pc_o;
    logic [31:0]             instr_o;
    logic [`FETCH_TAG_W-1:0] tag_o;
    logic                    instr_valid_o;

    logic [31:0]             model_mem [`IMEM_WORDS];   // What the tb wrote
    logic                    pred_here [`IMEM_WORDS];   // Word is a taken-predicted one
    logic [31:0]             pred_off  [`IMEM_WORDS];
    logic [31:0]             lfsr;
    logic [31:0]             exp_pc    [N_ROWS];
    logic [31:0]             exp_instr [N_ROWS];
    logic [`FETCH_TAG_W-1:0] exp_tag   [N_ROWS];
    logic                    exp_valid [N_ROWS];
    logic                    exp_ready [N_ROWS];        // Mid-run read completes here

    fetch_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois taps 32,22,2,1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] enc_jal(input logic [31:0] off);
        enc_jal = {off[20], off[10:1], off[11], off[19:12], 5'd1, instr_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [31:0] off);
        enc_branch = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11],
                      instr_pkg::OPC_BRANCH};                   // BEQ x1, x2
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel_i    <= 1'b1;                                     // Setup
        penable_i <= 1'b0;
        pwrite_i  <= 1'b1;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge clk);
        penable_i <= 1'b1;
        do @(negedge clk); while (!pready_o);                  // Wait states for the port
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= addr;
        @(posedge clk);
        penable_i <= 1'b1;
        do @(negedge clk); while (!pready_o);
        data = prdata_o;                                       // Valid with pready
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic load_program();
        logic [31:0] imm;
        logic [31:0] rd;
        logic [31:0] word;
        for (int w = 0; w < LOAD_WORDS; w++) begin
            take_bits(12, imm);
            take_bits(5, rd);
            word = {imm[11:0], rd[4:0], 3'b000, rd[4:0], 7'b001_0011}; // addi rd, rd, imm
            if (w == 6) begin
                word = enc_jal(32'h40);                        // 0x18 -> 0x58
                pred_here[w] = 1'b1;
                pred_off[w]  = 32'h40;
            end else if (w == 24) begin
                word = enc_branch(32'd16);                     // Forward, falls through
            end else if (w == 28) begin
                word = enc_branch(-32'sd12);                   // 0x70 -> 0x64
                pred_here[w] = 1'b1;
                pred_off[w]  = -32'sd12;
            end
            model_mem[w] = word;
            apb_write(w * 4, word);
        end
    endtask

    task automatic readback();
        logic [31:0] data;
        int          idx [6];
        idx = '{0, 6, 8, 24, 28, LOAD_WORDS - 1};
        for (int k = 0; k < 6; k++) begin
            apb_read(idx[k] * 4, data);
            check("prdata_o", data, model_mem[idx[k]]);
        end
    endtask

    // Cycle model of pc, tag, valid and prediction over the table
    task automatic build_expected();
        logic [31:0]             m_pc;
        logic [31:0]             m_pco;
        logic [31:0]             addr;
        logic [31:0]             tgt;
        logic [`FETCH_TAG_W-1:0] cur;
        logic [`FETCH_TAG_W-1:0] nxt;
        logic [`FETCH_TAG_W-1:0] cur_n;
        logic                    m_valid;
        logic                    stall;
        logic                    adv;
        logic                    redir;
        logic                    take;
        logic                    prev_setup;
        logic                    prev_stall;
        logic [6:0]              r;
        logic [`IMEM_AW-1:0]     wi;
        m_pc       = `FETCH_START_ADDR;
        m_pco      = `FETCH_START_ADDR;                        // Held by hazard during load
        cur        = '0;
        nxt        = '0;
        m_valid    = 1'b0;
        prev_setup = 1'b0;
        prev_stall = 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            wi           = m_pco[`IMEM_AW+1:2];
            exp_pc[i]    = m_pco;
            exp_tag[i]   = cur;
            exp_valid[i] = m_valid;
            exp_instr[i] = model_mem[wi];
            exp_ready[i] = prev_stall;                         // Access cycle after the grant
            r     = ROWS[i];
            stall = prev_setup;                                // Loader owns port after setup
            adv   = !r[6] && !stall;
            redir = |r[5:2];
            take  = m_valid && pred_here[wi] && adv && !redir && (cur == nxt);
            tgt   = m_pco + pred_off[wi];
            addr  = take ? tgt : m_pc;
            if (r[2]) m_pc = MEPC;
            else if (r[4] || r[3]) m_pc = MTVEC;
            else if (r[5]) m_pc = JUMP_TGT;
            else if (take) m_pc = tgt + 32'd4;
            else if (adv) m_pc = m_pc + 32'd4;
            if (adv) m_pco = addr;
            cur_n = adv ? nxt : cur;
            if (redir) nxt = cur + 1'b1;
            cur        = cur_n;
            m_valid    = !stall && !r[6];
            prev_setup = (r[1:0] == 2'd1);
            prev_stall = stall;
        end
    endtask

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: the run did not finish within its cycle budget");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [6:0] r;
        reset         = 1'b1;
        hazard_i      = 1'b0;
        jump_i        = 1'b0;
        jump_target_i = JUMP_TGT;
        mtvec_i       = MTVEC;
        mepc_i        = MEPC;
        exception_i   = 1'b0;
        mret_i        = 1'b0;
        irq_ack_i     = 1'b0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        lfsr          = 32'hf42ab096;
        for (int w = 0; w < `IMEM_WORDS; w++) begin
            model_mem[w] = '0;
            pred_here[w] = 1'b0;
            pred_off[w]  = '0;
        end
        repeat (4) @(posedge clk);
        reset    <= 1'b0;
        hazard_i <= 1'b1;                                      // Freeze fetch while loading
        load_program();
        readback();
        build_expected();
        for (int i = 0; i < N_ROWS; i++) begin
            r = ROWS[i];
            @(posedge clk);
            hazard_i    <= r[6];
            jump_i      <= r[5];
            exception_i <= r[4];
            irq_ack_i   <= r[3];
            mret_i      <= r[2];
            psel_i      <= (r[1:0] != 2'd0);
            penable_i   <= r[1];
            pwrite_i    <= 1'b0;
            paddr_i     <= RD_ADDR;
            @(negedge clk);
            check("pc_o", pc_o, exp_pc[i]);
            check("tag_o", 32'(tag_o), 32'(exp_tag[i]));
            check("instr_valid_o", 32'(instr_valid_o), 32'(exp_valid[i]));
            if (exp_valid[i]) begin
                check("instr_o", instr_o, exp_instr[i]);
            end
            check("pready_o", 32'(pready_o), 32'(exp_ready[i]));
            if (exp_ready[i]) begin
                check("prdata_o", prdata_o, model_mem[RD_ADDR >> 2]);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
logic/instr_pkg.sv
logic/mem_pkg.sv
logic/fetch_unit.sv
logic/branch_predecoder.sv
logic/imem_arbiter.sv
logic/imem.sv
logic/apb_loader.sv
logic/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module fetch_tb -o sim_fetch

# The simulator exits non-zero on a fatal, the log decides either way
./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
